/* common/lc3b_macros.svh */
`ifndef LC3B_MACROS_SVH
`define LC3B_MACROS_SVH

`default_nettype none

// first instruction address out of reset
`define LC3B_RESET_PC   16'h0000

// byte distance between consecutive instruction words
`define LC3B_WORD_STEP  16'd2

// trap vector to byte address
`define LC3B_TRAP_SHIFT 1

`default_nettype wire

`endif

/* common/lc3b_stage_if.sv */
`default_nettype none
`timescale 1ns/1ps

interface lc3b_stage_if;

    // opcodes per stage, invalid slots read as a nop branch
    lc3b_types_pkg::lc3b_opcode op_id;
    lc3b_types_pkg::lc3b_opcode op_ex;
    lc3b_types_pkg::lc3b_opcode op_mem;
    lc3b_types_pkg::lc3b_opcode op_mem_inter;
    lc3b_types_pkg::lc3b_opcode op_wb;

    lc3b_types_pkg::lc3b_nzp    nzp_wb;
    logic                       wb_valid;
    lc3b_types_pkg::lc3b_addr   wb_target;

    // ldi or sti sitting in MEM_inter, second access still owed
    logic                       mem_inter_pending;

    // instruction addresses for the data memory requests
    lc3b_types_pkg::lc3b_addr   pc_mem;
    lc3b_types_pkg::lc3b_addr   pc_mem_inter;

    modport src (
        output op_id, op_ex, op_mem, op_mem_inter, op_wb,
        output nzp_wb, wb_valid, wb_target, mem_inter_pending,
        output pc_mem, pc_mem_inter
    );

    modport view (
        input op_id, op_ex, op_mem, op_mem_inter, op_wb,
        input nzp_wb, wb_valid, wb_target, mem_inter_pending,
        input pc_mem, pc_mem_inter
    );

endinterface

`default_nettype wire

/* common/lc3b_types_pkg.sv */
`default_nettype none

package lc3b_types_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [15:0] lc3b_addr;
    typedef logic [2:0]  lc3b_nzp;

    // LC-3b opcode field, bits [15:12]
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [1:0] {
        fetch_idle,
        fetch_req,
        fetch_hold
    } fetch_state_e;

    // one pipeline slot
    typedef struct packed {
        logic       valid;
        lc3b_opcode op;
        lc3b_nzp    nzp;
        lc3b_addr   pc;
        lc3b_addr   target;
    } stage_rec_t;

endpackage

`default_nettype wire

/* hazard/hazard_detection.sv */
`default_nettype none
`timescale 1ns/1ps

module hazard_detection (
    input  wire logic   i_fetch_wait,
    input  wire logic   i_dmem_busy,
    lc3b_stage_if.view  stg,
    output logic        o_load,
    output logic        o_load_pc,
    output logic        o_redirect,
    output logic        o_flush,
    output logic        o_fetch_enable
);

    logic ctrl_in_flight;

    function automatic logic is_ctrl(input lc3b_types_pkg::lc3b_opcode op);
        logic hit;
        case (op)
            lc3b_types_pkg::op_jsr:  hit = 1'b1;
            lc3b_types_pkg::op_trap: hit = 1'b1;
            default:                 hit = 1'b0;
        endcase
        return hit;
    endfunction

    // jsr or trap anywhere before WB, nothing behind it may be fetched
    assign ctrl_in_flight = is_ctrl(stg.op_id) || is_ctrl(stg.op_ex) ||
                            is_ctrl(stg.op_mem) || is_ctrl(stg.op_mem_inter);

    always_comb begin
        o_fetch_enable = !ctrl_in_flight;
        o_redirect     = 1'b0;
        o_flush        = 1'b0;

        if (stg.wb_valid) begin
            case (stg.op_wb)
                lc3b_types_pkg::op_br: begin
                    // no condition codes here, any nzp bit means taken
                    if (stg.nzp_wb != 3'b000) begin
                        o_fetch_enable = 1'b0;
                        o_redirect     = 1'b1;
                        o_flush        = 1'b1;
                    end
                end
                lc3b_types_pkg::op_jsr: begin
                    o_fetch_enable = 1'b0;
                    o_redirect     = 1'b1;
                end
                lc3b_types_pkg::op_trap: begin
                    o_fetch_enable = 1'b0;
                    o_redirect     = 1'b1;
                end
                default: ;
            endcase
        end
    end

    // whole pipe waits on either memory
    assign o_load    = !(i_fetch_wait || i_dmem_busy);
    assign o_load_pc = o_load && o_redirect;

endmodule

`default_nettype wire

/* rtl/lc3b_fetch.sv */
`include "lc3b_macros.svh"
`default_nettype none
`timescale 1ns/1ps

module lc3b_fetch (
    input  wire logic                       i_clk,
    input  wire logic                       i_rst,
    input  wire logic                       i_load,
    input  wire logic                       i_load_pc,
    input  wire logic                       i_redirect,
    input  wire logic                       i_fetch_enable,
    input  wire lc3b_types_pkg::lc3b_addr   i_redirect_target,
    output logic                            o_imem_read,
    output lc3b_types_pkg::lc3b_addr        o_imem_addr,
    input  wire logic                       i_imem_resp,
    output logic                            o_fetch_valid,
    output lc3b_types_pkg::lc3b_addr        o_fetch_pc
);

    lc3b_types_pkg::fetch_state_e state;
    lc3b_types_pkg::lc3b_addr     pc;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= lc3b_types_pkg::fetch_idle;
            pc    <= `LC3B_RESET_PC;
        end else begin
            case (state)
                lc3b_types_pkg::fetch_idle: begin
                    // no new request while the PC is about to be replaced
                    if (i_fetch_enable && !i_redirect)
                        state <= lc3b_types_pkg::fetch_req;
                end
                lc3b_types_pkg::fetch_req: begin
                    if (i_imem_resp)
                        state <= lc3b_types_pkg::fetch_hold;
                end
                lc3b_types_pkg::fetch_hold: begin
                    if (i_load)
                        state <= lc3b_types_pkg::fetch_idle;
                end
                default: state <= lc3b_types_pkg::fetch_idle;
            endcase

            // a redirect wins over the step, the held word is dropped by the flush
            if (i_load && i_load_pc)
                pc <= i_redirect_target;
            else if (i_load && state == lc3b_types_pkg::fetch_hold)
                pc <= pc + `LC3B_WORD_STEP;
        end
    end

    // request held until the response, pc stays put meanwhile
    assign o_imem_read   = (state == lc3b_types_pkg::fetch_req);
    assign o_imem_addr   = pc;
    assign o_fetch_valid = o_imem_read && i_imem_resp;
    assign o_fetch_pc    = pc;

endmodule

`default_nettype wire

/* rtl/lc3b_mem_access.sv */
`default_nettype none
`timescale 1ns/1ps

module lc3b_mem_access (
    input  wire logic                   i_clk,
    input  wire logic                   i_rst,
    input  wire logic                   i_load,
    lc3b_stage_if.view                  stg,
    output logic                        o_dmem_read,
    output logic                        o_dmem_write,
    output lc3b_types_pkg::lc3b_addr    o_dmem_addr,
    input  wire logic                   i_dmem_resp,
    output logic                        o_dmem_busy
);

    logic done_inter;
    logic done_mem;
    logic need_mem;
    logic mem_is_read;
    logic serve_inter;
    logic serve_mem;

    // first access of ldi and sti is the pointer read
    always_comb begin
        need_mem    = 1'b0;
        mem_is_read = 1'b0;
        case (stg.op_mem)
            lc3b_types_pkg::op_ldb, lc3b_types_pkg::op_ldr,
            lc3b_types_pkg::op_ldi, lc3b_types_pkg::op_sti: begin
                need_mem    = 1'b1;
                mem_is_read = 1'b1;
            end
            lc3b_types_pkg::op_stb, lc3b_types_pkg::op_str: need_mem = 1'b1;
            default: ;
        endcase
    end

    // older instruction in MEM_inter goes first
    assign serve_inter = stg.mem_inter_pending && !done_inter;
    assign serve_mem   = need_mem && !done_mem && !serve_inter;

    assign o_dmem_read  = (serve_inter && stg.op_mem_inter == lc3b_types_pkg::op_ldi) ||
                          (serve_mem && mem_is_read);
    assign o_dmem_write = (serve_inter && stg.op_mem_inter == lc3b_types_pkg::op_sti) ||
                          (serve_mem && !mem_is_read);
    assign o_dmem_addr  = serve_inter ? stg.pc_mem_inter : stg.pc_mem;
    assign o_dmem_busy  = serve_inter || serve_mem;

    always_ff @(posedge i_clk) begin
        if (i_rst || i_load) begin
            done_inter <= 1'b0;
            done_mem   <= 1'b0;
        end else if (i_dmem_resp) begin
            if (serve_inter)
                done_inter <= 1'b1;
            else if (serve_mem)
                done_mem <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/lc3b_pipe_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

module lc3b_pipe_ctrl (
    input  wire logic                       i_clk,
    input  wire logic                       i_rst,
    output logic                            o_imem_read,
    output lc3b_types_pkg::lc3b_addr        o_imem_addr,
    input  wire logic                       i_imem_resp,
    input  wire lc3b_types_pkg::lc3b_word   i_imem_rdata,
    output logic                            o_dmem_read,
    output logic                            o_dmem_write,
    output lc3b_types_pkg::lc3b_addr        o_dmem_addr,
    input  wire logic                       i_dmem_resp,
    output logic                            o_retire_valid,
    output lc3b_types_pkg::lc3b_addr        o_retire_pc,
    output lc3b_types_pkg::lc3b_opcode      o_retire_op
);

    logic                     load;
    logic                     load_pc;
    logic                     flush;
    logic                     redirect;
    logic                     fetch_enable;
    logic                     dmem_busy;
    logic                     fetch_valid;
    lc3b_types_pkg::lc3b_addr fetch_pc;

    lc3b_stage_if stg ();

    lc3b_fetch u_fetch (
        .i_clk             (i_clk),
        .i_rst             (i_rst),
        .i_load            (load),
        .i_load_pc         (load_pc),
        .i_redirect        (redirect),
        .i_fetch_enable    (fetch_enable),
        .i_redirect_target (stg.wb_target),
        .o_imem_read       (o_imem_read),
        .o_imem_addr       (o_imem_addr),
        .i_imem_resp       (i_imem_resp),
        .o_fetch_valid     (fetch_valid),
        .o_fetch_pc        (fetch_pc)
    );

    lc3b_stage_regs u_stage_regs (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_load         (load),
        .i_flush        (flush),
        .i_fetch_valid  (fetch_valid),
        .i_fetch_pc     (fetch_pc),
        .i_imem_rdata   (i_imem_rdata),
        .o_retire_valid (o_retire_valid),
        .o_retire_pc    (o_retire_pc),
        .o_retire_op    (o_retire_op),
        .stg            (stg.src)
    );

    lc3b_mem_access u_mem_access (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_load       (load),
        .stg          (stg.view),
        .o_dmem_read  (o_dmem_read),
        .o_dmem_write (o_dmem_write),
        .o_dmem_addr  (o_dmem_addr),
        .i_dmem_resp  (i_dmem_resp),
        .o_dmem_busy  (dmem_busy)
    );

    // an open instruction request is the fetch wait
    hazard_detection u_hazard (
        .i_fetch_wait   (o_imem_read),
        .i_dmem_busy    (dmem_busy),
        .stg            (stg.view),
        .o_load         (load),
        .o_load_pc      (load_pc),
        .o_redirect     (redirect),
        .o_flush        (flush),
        .o_fetch_enable (fetch_enable)
    );

endmodule

`default_nettype wire

/* rtl/lc3b_stage_regs.sv */
`include "lc3b_macros.svh"
`default_nettype none
`timescale 1ns/1ps

module lc3b_stage_regs (
    input  wire logic                       i_clk,
    input  wire logic                       i_rst,
    input  wire logic                       i_load,
    input  wire logic                       i_flush,
    input  wire logic                       i_fetch_valid,
    input  wire lc3b_types_pkg::lc3b_addr   i_fetch_pc,
    input  wire lc3b_types_pkg::lc3b_word   i_imem_rdata,
    output logic                            o_retire_valid,
    output lc3b_types_pkg::lc3b_addr        o_retire_pc,
    output lc3b_types_pkg::lc3b_opcode      o_retire_op,
    lc3b_stage_if.src                       stg
);

    lc3b_types_pkg::stage_rec_t if_rec, id_rec, ex_rec, mem_rec, inter_rec, wb_rec;

    function automatic lc3b_types_pkg::stage_rec_t decode(
        input lc3b_types_pkg::lc3b_word w,
        input lc3b_types_pkg::lc3b_addr pc
    );
        lc3b_types_pkg::stage_rec_t rec;
        lc3b_types_pkg::lc3b_addr   next_pc;
        next_pc    = pc + `LC3B_WORD_STEP;
        rec.valid  = 1'b1;
        rec.op     = lc3b_types_pkg::lc3b_opcode'(w[15:12]);
        rec.nzp    = '0;
        rec.pc     = pc;
        rec.target = next_pc;
        case (rec.op)
            lc3b_types_pkg::op_br: begin
                rec.nzp    = w[11:9];
                rec.target = next_pc + {{6{w[8]}}, w[8:0], 1'b0};
            end
            lc3b_types_pkg::op_jsr: begin
                // jsrr needs a base register, carried like jmp
                if (w[11])
                    rec.target = next_pc + {{4{w[10]}}, w[10:0], 1'b0};
                else
                    rec.op = lc3b_types_pkg::op_jmp;
            end
            lc3b_types_pkg::op_trap: rec.target = {8'h00, w[7:0]} << `LC3B_TRAP_SHIFT;
            default: ;
        endcase
        return rec;
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            if_rec.valid    <= 1'b0;
            id_rec.valid    <= 1'b0;
            ex_rec.valid    <= 1'b0;
            mem_rec.valid   <= 1'b0;
            inter_rec.valid <= 1'b0;
            wb_rec.valid    <= 1'b0;
        end else if (i_load) begin
            wb_rec    <= inter_rec;
            inter_rec <= mem_rec;
            mem_rec   <= ex_rec;
            ex_rec    <= id_rec;
            id_rec    <= if_rec;
            if_rec.valid <= 1'b0;
            // everything behind the taken branch is wrong path
            if (i_flush) begin
                wb_rec.valid    <= 1'b0;
                inter_rec.valid <= 1'b0;
                mem_rec.valid   <= 1'b0;
                ex_rec.valid    <= 1'b0;
                id_rec.valid    <= 1'b0;
            end
        end else if (i_fetch_valid) begin
            if_rec <= decode(i_imem_rdata, i_fetch_pc);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst)
            o_retire_valid <= 1'b0;
        else
            o_retire_valid <= i_load && wb_rec.valid;
    end

    always_ff @(posedge i_clk) begin
        if (i_load && wb_rec.valid) begin
            o_retire_pc <= wb_rec.pc;
            o_retire_op <= wb_rec.op;
        end
    end

    // empty slots look like br with nzp 000
    assign stg.op_id        = id_rec.valid    ? id_rec.op    : lc3b_types_pkg::op_br;
    assign stg.op_ex        = ex_rec.valid    ? ex_rec.op    : lc3b_types_pkg::op_br;
    assign stg.op_mem       = mem_rec.valid   ? mem_rec.op   : lc3b_types_pkg::op_br;
    assign stg.op_mem_inter = inter_rec.valid ? inter_rec.op : lc3b_types_pkg::op_br;
    assign stg.op_wb        = wb_rec.valid    ? wb_rec.op    : lc3b_types_pkg::op_br;
    assign stg.nzp_wb       = wb_rec.valid    ? wb_rec.nzp   : '0;
    assign stg.wb_valid     = wb_rec.valid;
    assign stg.wb_target    = wb_rec.target;
    assign stg.pc_mem       = mem_rec.pc;
    assign stg.pc_mem_inter = inter_rec.pc;
    assign stg.mem_inter_pending = inter_rec.valid &&
        (inter_rec.op == lc3b_types_pkg::op_ldi || inter_rec.op == lc3b_types_pkg::op_sti);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# compile and run the testbench, the exit status is the simulator's
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f tb.f \
    --top-module tb_lc3b_pipe_ctrl \
    -o sim_tb_lc3b_pipe_ctrl

./obj_dir/sim_tb_lc3b_pipe_ctrl

/* tb.f */
+incdir+common
common/lc3b_types_pkg.sv
common/lc3b_stage_if.sv
rtl/lc3b_fetch.sv
rtl/lc3b_stage_regs.sv
rtl/lc3b_mem_access.sv
hazard/hazard_detection.sv
rtl/lc3b_pipe_ctrl.sv
verif/lc3b_pipe_ctrl_props.sv
verif/tb_lc3b_pipe_ctrl.sv

/* verif/lc3b_pipe_ctrl_props.sv */
`default_nettype none
`timescale 1ns/1ps

module lc3b_pipe_ctrl_props (
    input wire logic                     i_clk,
    input wire logic                     i_rst,
    input wire logic                     i_imem_read,
    input wire lc3b_types_pkg::lc3b_addr i_imem_addr,
    input wire logic                     i_imem_resp,
    input wire logic                     i_dmem_read,
    input wire logic                     i_dmem_write,
    input wire lc3b_types_pkg::lc3b_addr i_dmem_addr,
    input wire logic                     i_dmem_resp,
    input wire logic                     i_load,
    input wire logic                     i_flush
);

    // requests stay put until answered
    a_imem_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_imem_read && !i_imem_resp) |=> (i_imem_read && $stable(i_imem_addr)))
        else $error("instruction request dropped or moved before its response");

    a_dmem_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        ((i_dmem_read || i_dmem_write) && !i_dmem_resp) |=>
        ($stable(i_dmem_read) && $stable(i_dmem_write) && $stable(i_dmem_addr)))
        else $error("data request dropped or moved before its response");

    a_dmem_onehot: assert property (@(posedge i_clk) disable iff (i_rst)
        !(i_dmem_read && i_dmem_write))
        else $error("data read and write raised together");

    // wrong-path word is dropped, next request waits for the new PC
    a_flush_no_fetch: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_flush && i_load) |=> !i_imem_read)
        else $error("instruction request right after a flush");

endmodule

`default_nettype wire

/* verif/tb_lc3b_pipe_ctrl.sv */
`include "lc3b_macros.svh"
`default_nettype none
`timescale 1ns/1ps

module tb_lc3b_pipe_ctrl;

    localparam int NUM_RETIRE        = 200;
    localparam int CYCLES_PER_RETIRE = 40;
    localparam int RESET_CYCLES      = 5;
    localparam int PROG_WORDS        = 64;

    logic                       i_clk;
    logic                       i_rst;
    logic                       o_imem_read;
    lc3b_types_pkg::lc3b_addr   o_imem_addr;
    logic                       i_imem_resp;
    lc3b_types_pkg::lc3b_word   i_imem_rdata;
    logic                       o_dmem_read;
    logic                       o_dmem_write;
    lc3b_types_pkg::lc3b_addr   o_dmem_addr;
    logic                       i_dmem_resp;
    logic                       o_retire_valid;
    lc3b_types_pkg::lc3b_addr   o_retire_pc;
    lc3b_types_pkg::lc3b_opcode o_retire_op;

    lc3b_types_pkg::lc3b_word   prog [0:PROG_WORDS-1];
    logic [31:0]                lfsr_state;
    int                         retired;
    // data memory accesses seen per instruction address since its last retirement
    int                         acc_count [lc3b_types_pkg::lc3b_addr];
    int                         acc_seq   [lc3b_types_pkg::lc3b_addr];

    lc3b_pipe_ctrl i_lc3b_pipe_ctrl (.*);

    bind lc3b_pipe_ctrl lc3b_pipe_ctrl_props u_props (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_imem_read  (o_imem_read),
        .i_imem_addr  (o_imem_addr),
        .i_imem_resp  (i_imem_resp),
        .i_dmem_read  (o_dmem_read),
        .i_dmem_write (o_dmem_write),
        .i_dmem_addr  (o_dmem_addr),
        .i_dmem_resp  (i_dmem_resp),
        .i_load       (load),
        .i_flush      (flush)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 32'h80200003;
        return n;
    endfunction

    // one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            val        = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return val;
    endfunction

    // control targets stay inside the 64 words, last word spins on itself
    task automatic build_program();
        logic [31:0] r;
        logic [3:0]  op;
        int          tgt;
        int          off;
        for (int i = 0; i < PROG_WORDS - 1; i++) begin
            r   = rand_bits(4);
            op  = r[3:0];
            r   = rand_bits(6);
            tgt = {26'd0, r[5:0]};
            off = tgt - (i + 1);
            case (op)
                4'b0000: begin
                    r       = rand_bits(3);
                    prog[i] = {4'b0000, r[2:0], off[8:0]};
                end
                4'b0100: prog[i] = {4'b0100, 1'b1, off[10:0]};
                4'b1111: prog[i] = {4'b1111, 4'b0000, tgt[7:0]};
                default: begin
                    r       = rand_bits(12);
                    prog[i] = {op, r[11:0]};
                end
            endcase
        end
        prog[PROG_WORDS - 1] = {4'b0000, 3'b111, 9'h1ff};
    endtask

    function automatic lc3b_types_pkg::lc3b_word fetch_word(input lc3b_types_pkg::lc3b_addr a);
        lc3b_types_pkg::lc3b_word w;
        // only wrong-path fetches run past the program, they read a nop branch
        if (a < 16'd128)
            w = prog[a[6:1]];
        else
            w = 16'h0000;
        return w;
    endfunction

    function automatic lc3b_types_pkg::lc3b_addr ref_next_pc(
        input lc3b_types_pkg::lc3b_addr pc,
        input lc3b_types_pkg::lc3b_word w
    );
        int seq_pc;
        int nxt;
        seq_pc = {16'd0, pc} + 2;
        nxt    = seq_pc;
        case (w[15:12])
            // no condition codes, any nzp bit takes the branch
            4'b0000: if (w[11:9] != 3'b000) nxt = seq_pc + 2 * {{23{w[8]}}, w[8:0]};
            4'b0100: if (w[11]) nxt = seq_pc + 2 * {{21{w[10]}}, w[10:0]};
            4'b1111: nxt = 2 * {24'd0, w[7:0]};
            default: ;
        endcase
        return nxt[15:0];
    endfunction

    // order holds two bits per access, 1 for a read and 2 for a write
    function automatic void expected_accesses(
        input  lc3b_types_pkg::lc3b_opcode op,
        output int                         count,
        output int                         order
    );
        case (op)
            lc3b_types_pkg::op_ldb, lc3b_types_pkg::op_ldr: begin
                count = 1;
                order = 1;
            end
            lc3b_types_pkg::op_stb, lc3b_types_pkg::op_str: begin
                count = 1;
                order = 2;
            end
            lc3b_types_pkg::op_ldi: begin
                count = 2;
                order = 5;
            end
            lc3b_types_pkg::op_sti: begin
                count = 2;
                order = 6;
            end
            default: begin
                count = 0;
                order = 0;
            end
        endcase
    endfunction

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_addr(
        input string                    name,
        input lc3b_types_pkg::lc3b_addr exp,
        input lc3b_types_pkg::lc3b_addr act
    );
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_op(
        input string                      name,
        input lc3b_types_pkg::lc3b_opcode exp,
        input lc3b_types_pkg::lc3b_opcode act
    );
        if (act !== exp) begin
            $display("Fail %s: expected %s, actual %s", name, exp.name(), act.name());
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    initial begin : memory_models
        logic [31:0] r;
        int          imem_wait;
        int          dmem_wait;
        i_imem_resp  = 1'b0;
        i_imem_rdata = '0;
        i_dmem_resp  = 1'b0;
        lfsr_state   = 32'he82424d7;
        imem_wait    = -1;
        dmem_wait    = -1;
        build_program();
        forever begin
            @(posedge i_clk);
            #1;
            // a response lasts one cycle, whatever is requested now is new
            i_imem_resp = 1'b0;
            i_dmem_resp = 1'b0;
            if (o_imem_read) begin
                if (imem_wait < 0) begin
                    r         = rand_bits(2);
                    imem_wait = {30'd0, r[1:0]};
                end
                if (imem_wait == 0) begin
                    i_imem_resp  = 1'b1;
                    i_imem_rdata = fetch_word(o_imem_addr);
                    imem_wait    = -1;
                end else begin
                    imem_wait = imem_wait - 1;
                end
            end
            if (o_dmem_read || o_dmem_write) begin
                if (dmem_wait < 0) begin
                    r         = rand_bits(2);
                    dmem_wait = {30'd0, r[1:0]};
                end
                if (dmem_wait == 0) begin
                    i_dmem_resp = 1'b1;
                    dmem_wait   = -1;
                end else begin
                    dmem_wait = dmem_wait - 1;
                end
            end
        end
    end

    initial begin : compare_retire
        lc3b_types_pkg::lc3b_addr exp_pc;
        lc3b_types_pkg::lc3b_word word;
        logic                     seen_fetch;
        int                       exp_cnt;
        int                       exp_order;
        int                       got_cnt;
        int                       got_order;
        retired    = 0;
        exp_pc     = `LC3B_RESET_PC;
        seen_fetch = 1'b0;
        forever begin
            @(negedge i_clk);
            if (!i_rst) begin
                if (!seen_fetch) begin
                    if (o_dmem_read || o_dmem_write || o_retire_valid) begin
                        $display("Data request or retire strobe before the first fetch");
                        abort_run();
                    end
                    if (o_imem_read) begin
                        check_addr("first fetch", `LC3B_RESET_PC, o_imem_addr);
                        seen_fetch = 1'b1;
                    end
                end
                // handshake completes on the coming rising edge
                if ((o_dmem_read || o_dmem_write) && i_dmem_resp) begin
                    if (!acc_count.exists(o_dmem_addr)) begin
                        acc_count[o_dmem_addr] = 0;
                        acc_seq[o_dmem_addr]   = 0;
                    end
                    acc_count[o_dmem_addr] = acc_count[o_dmem_addr] + 1;
                    acc_seq[o_dmem_addr]   = acc_seq[o_dmem_addr] * 4 + (o_dmem_write ? 2 : 1);
                end
                if (o_retire_valid) begin
                    word = prog[exp_pc[6:1]];
                    check_addr($sformatf("retire %0d address", retired), exp_pc, o_retire_pc);
                    check_op($sformatf("retire %0d opcode", retired),
                             lc3b_types_pkg::lc3b_opcode'(word[15:12]), o_retire_op);
                    expected_accesses(lc3b_types_pkg::lc3b_opcode'(word[15:12]),
                                      exp_cnt, exp_order);
                    got_cnt   = 0;
                    got_order = 0;
                    if (acc_count.exists(exp_pc)) begin
                        got_cnt   = acc_count[exp_pc];
                        got_order = acc_seq[exp_pc];
                        acc_count.delete(exp_pc);
                        acc_seq.delete(exp_pc);
                    end
                    check_count($sformatf("retire %0d access count", retired), exp_cnt, got_cnt);
                    check_count($sformatf("retire %0d access order", retired), exp_order,
                                got_order);
                    // younger slots were flushed, their accesses were wrong path
                    if (word[15:12] == 4'b0000 && word[11:9] != 3'b000) begin
                        acc_count.delete();
                        acc_seq.delete();
                    end
                    exp_pc  = ref_next_pc(exp_pc, word);
                    retired = retired + 1;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (RESET_CYCLES + NUM_RETIRE * CYCLES_PER_RETIRE) @(posedge i_clk);
        $display("Timeout with %0d of %0d instructions retired", retired, NUM_RETIRE);
        abort_run();
    end

    initial begin : run_test
        i_rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        wait (retired == NUM_RETIRE);
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire
